// ==== riu_reset_infra.f ====
+incdir+verilog
verilog/riu_reset_pkg.sv
verilog/input_reset_conditioner.sv
verilog/domain_reset_stretcher.sv
verilog/pll_gate_timer.sv
verilog/riu_reset_infra.sv
dv/tb_clock_gen.sv
dv/riu_reset_infra_assertions.sv
dv/riu_reset_infra_tb.sv

// ==== dv/riu_reset_infra_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module riu_reset_infra_tb;

  localparam int OUT_MMCM    = 0;    // Selectors for wait_level
  localparam int OUT_RIU     = 1;
  localparam int OUT_MB      = 2;
  localparam int OUT_GATE    = 3;
  localparam int OUT_SYS     = 4;
  localparam int WAIT_LIMIT  = 300;  // Cycles before a wait gives up
  localparam int LOCK_EVENTS = 6;    // Alternating PLL and MMCM lock drops

  logic        riu_clk;
  logic        sys_rst;
  logic        pll_lock;
  logic        mmcm_lock;
  wire         mmcm_rst;
  wire         rstdiv1;
  wire         reset_ub;
  wire         pllgate;
  logic [31:0] lfsr_state = 32'h3455226d;  // Galois LFSR state

  tb_clock_gen u_clk_gen (
    .riu_clk (riu_clk),
    .sys_rst (sys_rst)
  );

  riu_reset_infra riu_reset_infra_i (
    .riu_clk   (riu_clk),
    .sys_rst   (sys_rst),
    .pll_lock  (pll_lock),
    .mmcm_lock (mmcm_lock),
    .mmcm_rst  (mmcm_rst),
    .rstdiv1   (rstdiv1),
    .reset_ub  (reset_ub),
    .pllgate   (pllgate)
  );

  // One LFSR step per bit taken
  function automatic logic lfsr_step();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'hD000_0001;  // Taps 32, 31, 29, 1
    end
    return lsb;
  endfunction

  function automatic int rand_bits(input int width);
    int val;
    val = 0;
    for (int i = 0; i < width; i++) begin
      val = (val << 1) | int'(lfsr_step());
    end
    return val;
  endfunction

  function automatic logic out_level(input int sel);
    logic lvl;
    case (sel)
      OUT_MMCM: lvl = mmcm_rst;
      OUT_RIU:  lvl = rstdiv1;
      OUT_MB:   lvl = reset_ub;
      OUT_GATE: lvl = pllgate;
      default:  lvl = sys_rst;
    endcase
    return lvl;
  endfunction

  // Sampled on the falling edge, away from the flop updates
  task automatic wait_level(input int sel, input logic lvl, input string what);
    int cycles;
    cycles = 0;
    while (out_level(sel) !== lvl) begin
      if (cycles >= WAIT_LIMIT) begin
        $display("Timeout: %s did not reach %0b within %0d cycles", what, lvl, WAIT_LIMIT);
        $display("Finished with errors");
        $fatal(1, "Wait timed out");
      end else begin
        @(negedge riu_clk);
        cycles++;
      end
    end
  endtask

  task automatic drive_after_edge(input int cycles);
    repeat (cycles) @(posedge riu_clk);
    #1;                                // Inputs change 1 ns after the edge
  endtask

  task automatic wait_recovery(input string what);
    wait_level(OUT_RIU, 1'b0, {"rstdiv1 release ", what});
    wait_level(OUT_MB, 1'b0, {"reset_ub release ", what});
    wait_level(OUT_GATE, 1'b1, {"pllgate open ", what});
  endtask

  initial begin
    int gap;
    int hold;
    pll_lock  = 1'b0;
    mmcm_lock = 1'b0;
    @(negedge riu_clk);
    wait_level(OUT_SYS, 1'b0, "sys_rst release");
    drive_after_edge(3);
    mmcm_lock = 1'b1;                  // Locks arrive inside the input stretch
    drive_after_edge(4);
    pll_lock = 1'b1;
    wait_level(OUT_MMCM, 1'b1, "mmcm_rst pulse start");
    wait_level(OUT_MMCM, 1'b0, "mmcm_rst pulse end");
    wait_recovery("after power-up");
    for (int n = 0; n < LOCK_EVENTS; n++) begin
      gap  = 1 + rand_bits(4);         // 1 to 16 quiet cycles
      hold = 1 + (rand_bits(6) % 40);  // Lock lost for 1 to 40 cycles
      drive_after_edge(gap);
      if (n % 2 == 0) begin
        pll_lock = 1'b0;
      end else begin
        mmcm_lock = 1'b0;
      end
      drive_after_edge(hold);
      pll_lock  = 1'b1;
      mmcm_lock = 1'b1;
      wait_level(OUT_RIU, 1'b1, "rstdiv1 after a lock drop");
      wait_recovery("after a lock drop");
    end
    drive_after_edge(4);               // Let the last checks settle
    @(negedge riu_clk);
    if (riu_reset_infra_i.u_checks.fail_cnt == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "Assertion failures were reported");
    end
  end

  // Stops at the first failed check
  always @(negedge riu_clk) begin
    if (riu_reset_infra_i.u_checks.fail_cnt != 0) begin
      $display("A DUT check failed, see the message above");
      $display("Finished with errors");
      $fatal(1, "Stopping at the first failed check");
    end
  end

endmodule

`default_nettype wire

// ==== dv/riu_reset_infra_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riu_reset_settings.svh"

module riu_reset_infra_assertions (
  input wire riu_clk,
  input wire sys_rst,
  input wire pll_lock,
  input wire mmcm_lock,
  input wire mmcm_rst,
  input wire rstdiv1,
  input wire reset_ub,
  input wire pllgate,
  input wire rst_req_riu,  // Internal request from the conditioner
  input wire rst_req_mb
);

  localparam int RISE_LIMIT = 11;                       // Request flop plus stretcher delay
  localparam int RIU_MIN = `RIU_RIU_STRETCH + 6;
  localparam int MB_MIN = `RIU_MB_STRETCH + 6;
  localparam int GATE_MIN = `RIU_PLL_GATE_LIMIT + 1;

  int   fail_cnt = 0;  // Failed checks so far, polled by the testbench
  int   riu_low_cnt;   // Cycles since the RIU request fell
  int   mb_low_cnt;    // Cycles since the MicroBlaze request fell
  int   quiet_cnt;     // Cycles with both branch resets low
  logic mmcm_q;        // mmcm_rst one cycle back
  logic pulse_done;    // MMCM pulse has ended

  always_ff @(posedge riu_clk or posedge sys_rst) begin
    if (sys_rst) begin
      riu_low_cnt <= 0;
      mb_low_cnt  <= 0;
      quiet_cnt   <= 0;
      mmcm_q      <= 1'b0;
      pulse_done  <= 1'b0;
    end else begin
      riu_low_cnt <= rst_req_riu ? 0 : ((riu_low_cnt < 255) ? riu_low_cnt + 1 : riu_low_cnt);
      mb_low_cnt  <= rst_req_mb ? 0 : ((mb_low_cnt < 255) ? mb_low_cnt + 1 : mb_low_cnt);
      quiet_cnt   <= (rstdiv1 || reset_ub) ? 0 : ((quiet_cnt < 255) ? quiet_cnt + 1 : quiet_cnt);
      mmcm_q      <= mmcm_rst;
      pulse_done  <= pulse_done | (mmcm_q & ~mmcm_rst);  // Falling edge seen
    end
  end

  reset_values: assert property (@(posedge riu_clk)
    sys_rst |-> (rstdiv1 && reset_ub && !pllgate && !mmcm_rst))
    else begin
      fail_cnt++;
      $error("ERR reset_values: expected 1100, actual %b%b%b%b", $sampled(rstdiv1),
             $sampled(reset_ub), $sampled(pllgate), $sampled(mmcm_rst));
    end

  mmcm_pulse: assert property (@(posedge riu_clk) disable iff (sys_rst)
    $rose(mmcm_rst) |-> mmcm_rst [* `RIU_MMCM_PULSE] ##1 !mmcm_rst)
    else begin
      fail_cnt++;
      $error("mmcm_rst pulse did not last exactly %0d cycles", `RIU_MMCM_PULSE);
    end

  mmcm_once: assert property (@(posedge riu_clk) disable iff (sys_rst)
    pulse_done |-> !mmcm_rst)
    else begin
      fail_cnt++;
      $error("mmcm_rst came back after its single pulse");
    end

  riu_release: assert property (@(posedge riu_clk) disable iff (sys_rst)
    $fell(rstdiv1) |-> (riu_low_cnt >= RIU_MIN && riu_low_cnt <= RIU_MIN + 2))
    else begin
      fail_cnt++;
      $error("ERR riu_release: expected %0d to %0d cycles, actual %0d",
             RIU_MIN, RIU_MIN + 2, $sampled(riu_low_cnt));
    end

  mb_release: assert property (@(posedge riu_clk) disable iff (sys_rst)
    $fell(reset_ub) |-> (mb_low_cnt >= MB_MIN && mb_low_cnt <= MB_MIN + 2))
    else begin
      fail_cnt++;
      $error("ERR mb_release: expected %0d to %0d cycles, actual %0d",
             MB_MIN, MB_MIN + 2, $sampled(mb_low_cnt));
    end

  release_order: assert property (@(posedge riu_clk) disable iff (sys_rst)
    $fell(reset_ub) |-> !rstdiv1)
    else begin
      fail_cnt++;
      $error("reset_ub was released while rstdiv1 was still high");
    end

  pll_drop_riu: assert property (@(posedge riu_clk) disable iff (sys_rst)
    ($fell(pll_lock) && mmcm_lock) |-> ##[1:RISE_LIMIT] rstdiv1)
    else begin
      fail_cnt++;
      $error("rstdiv1 did not rise within %0d cycles of a PLL lock drop", RISE_LIMIT);
    end

  pll_drop_mb: assert property (@(posedge riu_clk) disable iff (sys_rst)
    ($fell(pll_lock) && mmcm_lock && !reset_ub) |-> !reset_ub [* RISE_LIMIT])
    else begin
      fail_cnt++;
      $error("reset_ub rose on a PLL lock drop");
    end

  mmcm_drop: assert property (@(posedge riu_clk) disable iff (sys_rst)
    $fell(mmcm_lock) |-> ##[1:RISE_LIMIT] (rstdiv1 && reset_ub))
    else begin
      fail_cnt++;
      $error("Both resets did not rise within %0d cycles of an MMCM lock drop", RISE_LIMIT);
    end

  gate_delay: assert property (@(posedge riu_clk) disable iff (sys_rst)
    $rose(pllgate) |-> (quiet_cnt >= GATE_MIN && quiet_cnt <= GATE_MIN + 1))
    else begin
      fail_cnt++;
      $error("ERR gate_delay: expected %0d to %0d cycles, actual %0d",
             GATE_MIN, GATE_MIN + 1, $sampled(quiet_cnt));
    end

  gate_closed: assert property (@(posedge riu_clk) disable iff (sys_rst)
    pllgate |-> !$past(rstdiv1 || reset_ub))
    else begin
      fail_cnt++;
      $error("pllgate was high one cycle after a branch reset was high");
    end

endmodule

bind riu_reset_infra riu_reset_infra_assertions u_checks (
  .riu_clk     (riu_clk),
  .sys_rst     (sys_rst),
  .pll_lock    (pll_lock),
  .mmcm_lock   (mmcm_lock),
  .mmcm_rst    (mmcm_rst),
  .rstdiv1     (rstdiv1),
  .reset_ub    (reset_ub),
  .pllgate     (pllgate),
  .rst_req_riu (rst_req_riu),
  .rst_req_mb  (rst_req_mb)
);

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic riu_clk,  // 4 ns RIU clock
  output logic sys_rst   // System reset, two cycles at start
);

  initial begin
    riu_clk = 1'b0;
    forever #2 riu_clk = ~riu_clk;     // Rising edges at 2, 6, 10 ns
  end

  initial begin
    sys_rst = 1'b0;
    #1 sys_rst = 1'b1;                 // Clean rising edge for the async reset
    repeat (2) @(posedge riu_clk);     // Held over two rising edges
    #1 sys_rst = 1'b0;                 // Released 1 ns after the edge
  end

endmodule

`default_nettype wire

// ==== verilog/riu_reset_infra.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riu_reset_settings.svh"

module riu_reset_infra (
  input  wire  riu_clk,    // RIU clock, the only domain here
  input  wire  sys_rst,    // Asynchronous system reset, active high
  input  wire  pll_lock,   // PLL locked
  input  wire  mmcm_lock,  // MMCM locked
  output logic mmcm_rst,   // MMCM reset pulse
  output logic rstdiv1,    // RIU domain reset
  output logic reset_ub,   // MicroBlaze reset
  output logic pllgate     // PLL clock gate enable
);

  logic rst_req_riu;  // Conditioner request for the RIU branch
  logic rst_req_mb;   // Conditioner request for the MicroBlaze branch

  // Input reset sync, stretch and MMCM pulse
  input_reset_conditioner u_input_rst (
    .riu_clk     (riu_clk),
    .sys_rst     (sys_rst),
    .pll_lock    (pll_lock),
    .mmcm_lock   (mmcm_lock),
    .mmcm_rst    (mmcm_rst),
    .rst_req_riu (rst_req_riu),
    .rst_req_mb  (rst_req_mb)
  );

  // RIU branch, shorter stretch
  domain_reset_stretcher #(
    .STRETCH (`RIU_RIU_STRETCH)
  ) u_riu_rst (
    .riu_clk (riu_clk),
    .sys_rst (sys_rst),
    .rst_req (rst_req_riu),
    .rst_out (rstdiv1)
  );

  // MicroBlaze branch, releases after RIU when locks are steady
  domain_reset_stretcher #(
    .STRETCH (`RIU_MB_STRETCH)
  ) u_mb_rst (
    .riu_clk (riu_clk),
    .sys_rst (sys_rst),
    .rst_req (rst_req_mb),
    .rst_out (reset_ub)
  );

  // Waits for both branches before enabling the PLL clock
  pll_gate_timer u_pll_gate (
    .riu_clk (riu_clk),
    .sys_rst (sys_rst),
    .rst_riu (rstdiv1),
    .rst_mb  (reset_ub),
    .pllgate (pllgate)
  );

endmodule

`default_nettype wire

// ==== verilog/pll_gate_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riu_reset_settings.svh"

module pll_gate_timer (
  input  wire  riu_clk,  // RIU clock
  input  wire  sys_rst,  // Asynchronous system reset, active high
  input  wire  rst_riu,  // RIU branch reset
  input  wire  rst_mb,   // MicroBlaze branch reset
  output logic pllgate   // PLL clock gate enable
);

  localparam riu_reset_pkg::rst_cnt_t GATE_LAST =
    riu_reset_pkg::rst_cnt_t'(`RIU_PLL_GATE_LIMIT - 1);

  riu_reset_pkg::gate_state_t state;     // Gate FSM state
  riu_reset_pkg::rst_cnt_t    gate_cnt;  // Quiet-cycle counter
  logic                       any_rst;   // Either branch still in reset

  assign any_rst = rst_riu | rst_mb;

  always_ff @(posedge riu_clk or posedge sys_rst) begin
    if (sys_rst) begin
      state    <= riu_reset_pkg::GATE_HOLD;
      gate_cnt <= '0;
    end else begin
      case (state)
        riu_reset_pkg::GATE_HOLD: begin
          gate_cnt <= '0;
          if (!any_rst) begin
            state <= riu_reset_pkg::GATE_COUNT; // Both branches released
          end
        end
        riu_reset_pkg::GATE_COUNT: begin
          if (any_rst) begin
            state <= riu_reset_pkg::GATE_HOLD;  // Restart on any new reset
          end else if (gate_cnt == GATE_LAST) begin
            state <= riu_reset_pkg::GATE_OPEN;  // Limit reached
          end else begin
            gate_cnt <= gate_cnt + 1'b1;
          end
        end
        riu_reset_pkg::GATE_OPEN: begin
          if (any_rst) begin
            state <= riu_reset_pkg::GATE_HOLD;  // Close the gate next cycle
          end
        end
        default: state <= riu_reset_pkg::GATE_HOLD;
      endcase
    end
  end

  // Decoded straight from the state flops
  assign pllgate = (state == riu_reset_pkg::GATE_OPEN);

endmodule

`default_nettype wire

// ==== verilog/domain_reset_stretcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module domain_reset_stretcher #(
  parameter int STRETCH = 24  // Cycles held after the request drops, up to 127
) (
  input  wire  riu_clk,  // Branch clock
  input  wire  sys_rst,  // Asynchronous system reset, active high
  input  wire  rst_req,  // Reset request level from the conditioner
  output logic rst_out   // Stretched branch reset
);

  localparam riu_reset_pkg::rst_cnt_t STRETCH_CNT = riu_reset_pkg::rst_cnt_t'(STRETCH);

  riu_reset_pkg::rst_sync_t req_sync;   // Request synchronizer
  riu_reset_pkg::rst_cnt_t  str_cnt;    // Stretch counter
  logic                     str_flag;   // High while stretching
  riu_reset_pkg::rst_pipe_t rel_pipe;   // Release delay pipeline

  // Request resynchronized into this branch
  always_ff @(posedge riu_clk or posedge sys_rst) begin
    if (sys_rst) begin
      req_sync <= '1;
    end else begin
      req_sync <= {req_sync[0], rst_req};      // Two stages
    end
  end

  // Held at full length while requested, then counts down
  always_ff @(posedge riu_clk or posedge sys_rst) begin
    if (sys_rst) begin
      str_cnt <= STRETCH_CNT;
    end else if (req_sync[1]) begin
      str_cnt <= STRETCH_CNT;                  // Reload on every requested cycle
    end else if (str_cnt != '0) begin
      str_cnt <= str_cnt - 1'b1;
    end
  end

  always_ff @(posedge riu_clk or posedge sys_rst) begin
    if (sys_rst) begin
      str_flag <= 1'b1;
    end else begin
      str_flag <= (str_cnt != '0);             // Reset active until count hits zero
    end
  end

  // Three pipeline stages plus one output flop
  // Gives downstream logic a few stable clocks around release
  always_ff @(posedge riu_clk or posedge sys_rst) begin
    if (sys_rst) begin
      rel_pipe <= '1;
      rst_out  <= 1'b1;
    end else begin
      rel_pipe <= {rel_pipe[1:0], str_flag};   // Shift toward the output
      rst_out  <= rel_pipe[2];                 // Final branch reset flop
    end
  end

endmodule

`default_nettype wire

// ==== verilog/input_reset_conditioner.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riu_reset_settings.svh"

module input_reset_conditioner (
  input  wire  riu_clk,      // RIU clock
  input  wire  sys_rst,      // Asynchronous system reset, active high
  input  wire  pll_lock,     // PLL locked
  input  wire  mmcm_lock,    // MMCM locked
  output logic mmcm_rst,     // Short reset pulse for the MMCM
  output logic rst_req_riu,  // Reset request to the RIU branch
  output logic rst_req_mb    // Reset request to the MicroBlaze branch
);

  riu_reset_pkg::rst_sync_t in_sync;  // Release synchronizer for sys_rst
  riu_reset_pkg::rst_cnt_t  in_cnt;   // Input stretch counter
  logic                     input_rst; // Stretched input reset
  logic                     mmcm_win;  // Counter inside the MMCM pulse window

  // Assert is immediate, release is pulled through two flops
  always_ff @(posedge riu_clk or posedge sys_rst) begin
    if (sys_rst) begin
      in_sync <= '1;                           // Both stages held active
    end else begin
      in_sync <= {in_sync[0], 1'b0};           // Shift in the released level
    end
  end

  // Stretch counter, reloaded while the synchronized reset is still high
  always_ff @(posedge riu_clk or posedge sys_rst) begin
    if (sys_rst) begin
      in_cnt <= riu_reset_pkg::rst_cnt_t'(`RIU_INPUT_STRETCH);
    end else if (in_sync[1]) begin
      in_cnt <= riu_reset_pkg::rst_cnt_t'(`RIU_INPUT_STRETCH); // Hold at full length
    end else if (in_cnt != '0) begin
      in_cnt <= in_cnt - 1'b1;                 // Count down after release
    end
  end

  // Last RIU_MMCM_PULSE counts before zero
  assign mmcm_win = (in_cnt != '0) &&
                    (in_cnt <= riu_reset_pkg::rst_cnt_t'(`RIU_MMCM_PULSE));

  // Stretched reset, high as long as the counter is running
  always_ff @(posedge riu_clk or posedge sys_rst) begin
    if (sys_rst) begin
      input_rst <= 1'b1;
    end else begin
      input_rst <= (in_cnt != '0);
    end
  end

  // MMCM reset pulse, one cycle behind the counter like input_rst
  always_ff @(posedge riu_clk or posedge sys_rst) begin
    if (sys_rst) begin
      mmcm_rst <= 1'b0;                        // Quiet while sys_rst is held
    end else begin
      mmcm_rst <= mmcm_win;                    // Exactly RIU_MMCM_PULSE cycles
    end
  end

  // Per-branch requests, registered so each branch sees a clean level
  always_ff @(posedge riu_clk or posedge sys_rst) begin
    if (sys_rst) begin
      rst_req_riu <= 1'b1;
      rst_req_mb  <= 1'b1;
    end else begin
      rst_req_riu <= input_rst | ~pll_lock | ~mmcm_lock; // RIU needs both locks
      rst_req_mb  <= input_rst | ~mmcm_lock;             // MicroBlaze ignores PLL lock
    end
  end

endmodule

`default_nettype wire

// ==== verilog/riu_reset_pkg.sv ====
`default_nettype none

package riu_reset_pkg;

  // Stretch and gate counter, 7 bits covers every limit up to 127
  typedef logic [6:0] rst_cnt_t;

  // Two-flop synchronizer for an incoming reset request
  typedef logic [1:0] rst_sync_t;

  // Release pipeline behind the stretch flag
  typedef logic [2:0] rst_pipe_t;

  // PLL gate sequencing
  typedef enum logic [1:0] {
    GATE_HOLD  = 2'd0,   // A branch reset is still active
    GATE_COUNT = 2'd1,   // Both released, counting quiet cycles
    GATE_OPEN  = 2'd2    // PLL clock enabled
  } gate_state_t;

endpackage

`default_nettype wire

// ==== verilog/riu_reset_settings.svh ====
`ifndef RIU_RESET_SETTINGS_SVH
`define RIU_RESET_SETTINGS_SVH

// Input conditioner stretch, counted in riu_clk cycles after sys_rst sync
`define RIU_INPUT_STRETCH 50

// MMCM reset window, active while the input counter sits in 1..this value
`define RIU_MMCM_PULSE 10

// Branch stretch lengths
`define RIU_RIU_STRETCH 12   // RIU branch (rstdiv1)
`define RIU_MB_STRETCH 24    // MicroBlaze branch, longer so it releases after RIU

// Quiet cycles after both branches release before the PLL clock is ungated
`define RIU_PLL_GATE_LIMIT 64

// All values above must fit the 7-bit counter type in the package

`endif
